/* verilog/hybrid_mul_settings.svh */
`ifndef HYBRID_MUL_SETTINGS_SVH
`define HYBRID_MUL_SETTINGS_SVH

`default_nettype none

// digit grid
`define HM_DIGIT_W      2
`define HM_GRID_N       4

// packed operand fields
`define HM_OPERAND_W    8
`define HM_LANES        2
`define HM_LANE_EXP_W   5
`define HM_EXP_FIELD_W  10

// sum of two 5-bit exponents
`define HM_PP_EXP_W     6

// product widths
`define HM_LANE_MANT_W  8
`define HM_INT_PROD_W   16

// register stages from input to result
`define HM_PIPE_DEPTH   2

`default_nettype wire

`endif

/* verilog/num_format_pkg.sv */
`include "hybrid_mul_settings.svh"
`default_nettype none

package num_format_pkg;

	// codes 2 and 3 are reserved, result is all zero
	typedef enum logic [1:0] {
		PREC_INT8  = 2'd0,
		PREC_FP8   = 2'd1,
		PREC_RSVD2 = 2'd2,
		PREC_RSVD3 = 2'd3
	} prec_mode_e;

	typedef enum logic {
		FMT_E4M3 = 1'b0,
		FMT_E5M2 = 1'b1
	} fp_format_e;

	// lane 1 sits in the upper half of exp and mant
	typedef struct packed {
		logic [`HM_LANES-1:0]       sign;
		logic [`HM_EXP_FIELD_W-1:0] exp;
		logic [`HM_OPERAND_W-1:0]   mant; // int8 value or two lane nibbles
	} operand_t;

	typedef struct packed {
		logic                       sign;
		logic [`HM_PP_EXP_W-1:0]    exp;  // biased sum
		logic [`HM_LANE_MANT_W-1:0] mant; // unnormalized
	} fp_lane_t;

	typedef struct packed {
		logic signed [`HM_INT_PROD_W-1:0] int_prod;
		fp_lane_t [`HM_LANES-1:0]         lane;
	} result_t;

endpackage

`default_nettype wire

/* verilog/datapath_pkg.sv */
`include "hybrid_mul_settings.svh"
`default_nettype none

package datapath_pkg;

	typedef logic [`HM_DIGIT_W-1:0]   digit_t;
	typedef logic [2*`HM_DIGIT_W-1:0] dprod_t; // one digit product

	typedef logic [`HM_INT_PROD_W-1:0]  int_mag_t;
	typedef logic [`HM_LANE_MANT_W-1:0] lane_mant_t;

	// multiplier [r][c] takes a_dig[r][c] and b_dig[r][c]
	typedef digit_t [`HM_GRID_N-1:0][`HM_GRID_N-1:0] digit_arr_t;

	typedef struct packed {
		digit_arr_t                                  a_dig;
		digit_arr_t                                  b_dig;
		logic [`HM_LANES-1:0][`HM_LANE_EXP_W-1:0]    a_exp; // effective, never 0 in fp8
		logic [`HM_LANES-1:0][`HM_LANE_EXP_W-1:0]    b_exp;
		logic [`HM_LANES-1:0]                        a_sign;
		logic [`HM_LANES-1:0]                        b_sign;
		num_format_pkg::prec_mode_e                  mode;
	} digit_grid_t;

	typedef dprod_t [`HM_GRID_N-1:0][`HM_GRID_N-1:0] prod_arr_t;

	// stage 1 register contents
	typedef struct packed {
		prod_arr_t                                   prod;
		logic [`HM_LANES-1:0][`HM_PP_EXP_W-1:0]      exp_sum;
		logic [`HM_LANES-1:0]                        sign;
		logic                                        int_neg;
		num_format_pkg::prec_mode_e                  mode;
	} pp_stage_t;

endpackage

`default_nettype wire

/* verilog/operand_unpack.sv */
`timescale 1ns/1ps
`include "hybrid_mul_settings.svh"
`default_nettype none

module operand_unpack (
	input  num_format_pkg::prec_mode_e prec_mode_i,
	input  num_format_pkg::fp_format_e fp_format_i,
	input  num_format_pkg::operand_t   a_i,
	input  num_format_pkg::operand_t   b_i,
	output datapath_pkg::digit_grid_t  grid_o
);
	import num_format_pkg::*;

	localparam int NIB_W = `HM_OPERAND_W / `HM_LANES;

	logic [`HM_OPERAND_W-1:0] a_mag;
	logic [`HM_OPERAND_W-1:0] b_mag;
	logic [`HM_LANES-1:0][2*`HM_DIGIT_W-1:0] a_sig;
	logic [`HM_LANES-1:0][2*`HM_DIGIT_W-1:0] b_sig;

	// -128 comes out as 128 unsigned
	function automatic logic [`HM_OPERAND_W-1:0] int_mag(input logic [`HM_OPERAND_W-1:0] v);
		if (v[`HM_OPERAND_W-1]) begin
			return ~v + 1'b1;
		end
		return v;
	endfunction

	function automatic logic [2*`HM_DIGIT_W-1:0] fp_sig(
		input fp_format_e               fmt,
		input logic [`HM_LANE_EXP_W-1:0] exp_f,
		input logic [NIB_W-1:0]          nib
	);
		logic hidden;
		hidden = (exp_f != '0);
		if (fmt == FMT_E5M2) begin
			return {1'b0, hidden, nib[1:0]};
		end
		return {hidden, nib[2:0]};
	endfunction

	function automatic logic [`HM_LANE_EXP_W-1:0] eff_exp(input logic [`HM_LANE_EXP_W-1:0] exp_f);
		return (exp_f == '0) ? `HM_LANE_EXP_W'(1) : exp_f; // subnormal
	endfunction

	assign a_mag = int_mag(a_i.mant);
	assign b_mag = int_mag(b_i.mant);

	always_comb begin
		for (int l = 0; l < `HM_LANES; l++) begin
			a_sig[l] = fp_sig(fp_format_i, a_i.exp[l*`HM_LANE_EXP_W +: `HM_LANE_EXP_W],
				a_i.mant[l*NIB_W +: NIB_W]);
			b_sig[l] = fp_sig(fp_format_i, b_i.exp[l*`HM_LANE_EXP_W +: `HM_LANE_EXP_W],
				b_i.mant[l*NIB_W +: NIB_W]);
		end
	end

	always_comb begin
		grid_o = '0;
		grid_o.mode = prec_mode_i;
		case (prec_mode_i)
			PREC_INT8: begin
				// a digits along columns, b digits along rows
				for (int r = 0; r < `HM_GRID_N; r++) begin
					for (int c = 0; c < `HM_GRID_N; c++) begin
						grid_o.a_dig[r][c] = a_mag[c*`HM_DIGIT_W +: `HM_DIGIT_W];
						grid_o.b_dig[r][c] = b_mag[r*`HM_DIGIT_W +: `HM_DIGIT_W];
					end
				end
				grid_o.a_sign[0] = a_i.mant[`HM_OPERAND_W-1];
				grid_o.b_sign[0] = b_i.mant[`HM_OPERAND_W-1];
			end
			PREC_FP8: begin
				for (int l = 0; l < `HM_LANES; l++) begin
					// lane l owns the 2x2 block on the diagonal
					for (int dr = 0; dr < 2; dr++) begin
						for (int dc = 0; dc < 2; dc++) begin
							grid_o.a_dig[2*l+dr][2*l+dc] = a_sig[l][dc*`HM_DIGIT_W +: `HM_DIGIT_W];
							grid_o.b_dig[2*l+dr][2*l+dc] = b_sig[l][dr*`HM_DIGIT_W +: `HM_DIGIT_W];
						end
					end
					grid_o.a_exp[l] = eff_exp(a_i.exp[l*`HM_LANE_EXP_W +: `HM_LANE_EXP_W]);
					grid_o.b_exp[l] = eff_exp(b_i.exp[l*`HM_LANE_EXP_W +: `HM_LANE_EXP_W]);
					grid_o.a_sign[l] = a_i.sign[l];
					grid_o.b_sign[l] = b_i.sign[l];
				end
			end
			default: begin
				// reserved, grid stays zero
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/partial_product_array.sv */
`timescale 1ns/1ps
`include "hybrid_mul_settings.svh"
`default_nettype none

module partial_product_array (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       valid_i,
	input  datapath_pkg::digit_grid_t  grid_i,
	output logic                       valid_o,
	output datapath_pkg::pp_stage_t    pp_o
);
	import num_format_pkg::*;
	import datapath_pkg::*;

	prod_arr_t prod;
	pp_stage_t pp_d;

	genvar r, c;
	generate
		for (r = 0; r < `HM_GRID_N; r++) begin : g_row
			for (c = 0; c < `HM_GRID_N; c++) begin : g_col
				// operands widen to 4 bits before the multiply
				assign prod[r][c] = grid_i.a_dig[r][c] * grid_i.b_dig[r][c];
			end
		end
	endgenerate

	always_comb begin
		pp_d.prod = prod;
		for (int l = 0; l < `HM_LANES; l++) begin
			pp_d.exp_sum[l] = {1'b0, grid_i.a_exp[l]} + {1'b0, grid_i.b_exp[l]}; // bias kept
			pp_d.sign[l] = grid_i.a_sign[l] ^ grid_i.b_sign[l];
		end
		// int8 signs ride in lane 0
		pp_d.int_neg = (grid_i.mode == PREC_INT8) && (grid_i.a_sign[0] ^ grid_i.b_sign[0]);
		pp_d.mode = grid_i.mode;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		pp_o <= pp_d; // loads every cycle
	end

endmodule

`default_nettype wire

/* verilog/product_combiner.sv */
`timescale 1ns/1ps
`include "hybrid_mul_settings.svh"
`default_nettype none

module product_combiner (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       valid_i,
	input  datapath_pkg::pp_stage_t    pp_i,
	output logic                       valid_o,
	output num_format_pkg::result_t    result_o
);
	import num_format_pkg::*;
	import datapath_pkg::*;

	int_mag_t                    int_mag;
	lane_mant_t [`HM_LANES-1:0]  lane_mant;
	result_t                     result_d;

	// full grid, weight 4^(r+c)
	always_comb begin
		int_mag = '0;
		for (int r = 0; r < `HM_GRID_N; r++) begin
			for (int c = 0; c < `HM_GRID_N; c++) begin
				int_mag = int_mag + (int_mag_t'(pp_i.prod[r][c]) << (`HM_DIGIT_W*(r+c)));
			end
		end
	end

	// diagonal blocks only
	always_comb begin
		lane_mant = '0;
		for (int l = 0; l < `HM_LANES; l++) begin
			for (int dr = 0; dr < 2; dr++) begin
				for (int dc = 0; dc < 2; dc++) begin
					lane_mant[l] = lane_mant[l]
						+ (lane_mant_t'(pp_i.prod[2*l+dr][2*l+dc]) << (`HM_DIGIT_W*(dr+dc)));
				end
			end
		end
	end

	always_comb begin
		result_d = '0;
		case (pp_i.mode)
			PREC_INT8: begin
				result_d.int_prod = pp_i.int_neg ? (~int_mag + 1'b1) : int_mag;
			end
			PREC_FP8: begin
				for (int l = 0; l < `HM_LANES; l++) begin
					result_d.lane[l].sign = pp_i.sign[l];
					result_d.lane[l].exp  = pp_i.exp_sum[l];
					result_d.lane[l].mant = lane_mant[l];
				end
			end
			default: begin
				// reserved modes give zero
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_o  <= 1'b0;
			result_o <= '0;
		end else begin
			valid_o  <= valid_i;
			result_o <= result_d;
		end
	end

endmodule

`default_nettype wire

/* verilog/hybrid_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hybrid_mul_top (
	input  logic                        clk,
	input  logic                        reset_i,
	input  logic                        in_valid_i,
	input  num_format_pkg::prec_mode_e  prec_mode_i,
	input  num_format_pkg::fp_format_e  fp_format_i,
	input  num_format_pkg::operand_t    a_i,
	input  num_format_pkg::operand_t    b_i,
	output logic                        out_valid_o,
	output num_format_pkg::result_t     result_o
);
	import datapath_pkg::*;

	digit_grid_t grid;
	pp_stage_t   pp;
	logic        pp_valid;

	operand_unpack operand_unpack_inst (
		.prec_mode_i (prec_mode_i),
		.fp_format_i (fp_format_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.grid_o      (grid)
	);

	// stage 1
	partial_product_array partial_product_array_inst (
		.clk     (clk),
		.reset_i (reset_i),
		.valid_i (in_valid_i),
		.grid_i  (grid),
		.valid_o (pp_valid),
		.pp_o    (pp)
	);

	// stage 2
	product_combiner product_combiner_inst (
		.clk      (clk),
		.reset_i  (reset_i),
		.valid_i  (pp_valid),
		.pp_i     (pp),
		.valid_o  (out_valid_o),
		.result_o (result_o)
	);

endmodule

`default_nettype wire

/* test/hybrid_mul_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module hybrid_mul_sva (
	input logic                       clk,
	input logic                       reset_i,
	input logic                       in_valid_i,
	input num_format_pkg::prec_mode_e prec_mode_i,
	input logic                       out_valid_i,
	input num_format_pkg::result_t    result_i
);
	import num_format_pkg::*;

	a_reset_quiet: assert property (@(posedge clk) reset_i |=> !out_valid_i)
		else $error("out_valid_o high after a reset edge");

	// two register stages, each cleared by reset
	a_latency: assert property (@(posedge clk) disable iff (reset_i)
		out_valid_i == ($past(in_valid_i, 2) && !$past(reset_i, 1) && !$past(reset_i, 2)))
		else $error("out_valid_o does not follow in_valid_i by two cycles");

	a_int8_lanes: assert property (@(posedge clk) disable iff (reset_i)
		(out_valid_i && $past(prec_mode_i, 2) == PREC_INT8) |-> (result_i.lane == '0))
		else $error("lanes not zero for an int8 result");

	a_fp8_int: assert property (@(posedge clk) disable iff (reset_i)
		(out_valid_i && $past(prec_mode_i, 2) == PREC_FP8) |-> (result_i.int_prod == '0))
		else $error("int_prod not zero for an fp8 result");

endmodule

bind hybrid_mul_top hybrid_mul_sva hybrid_mul_sva_inst (
	.clk         (clk),
	.reset_i     (reset_i),
	.in_valid_i  (in_valid_i),
	.prec_mode_i (prec_mode_i),
	.out_valid_i (out_valid_o),
	.result_i    (result_o)
);

`default_nettype wire

/* test/hybrid_mul_tb.sv */
`timescale 1ns/1ps
`include "hybrid_mul_settings.svh"
`default_nettype none

module hybrid_mul_tb;
	import num_format_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int N_CORNER = 7;
	localparam int N_RAND_INT = 200;
	localparam int N_RAND_FP = 100;
	localparam int N_STREAM = 50;
	localparam int N_GAPPED = 60;
	localparam int MAX_GAP = 3;
	localparam int N_RSVD = 8;
	localparam int N_TESTS = 6;
	// idle slots from gaps, reset and drains count too
	localparam int TOTAL_SLOTS = RESET_CYCLES + 2 + N_CORNER + N_RAND_INT + 2*N_RAND_FP
		+ N_STREAM + N_GAPPED*(MAX_GAP+1) + N_RSVD + N_TESTS*(`HM_PIPE_DEPTH+2);

	localparam logic [7:0] CORNER_A [N_CORNER] = '{8'd0, 8'd1, 8'hff, 8'd127, 8'h80, 8'h80, 8'd127};
	localparam logic [7:0] CORNER_B [N_CORNER] = '{8'hb3, 8'hff, 8'hff, 8'd127, 8'h80, 8'd127, 8'h80};

	logic       clk;
	logic       reset_i;
	logic       in_valid_i;
	prec_mode_e prec_mode_i;
	fp_format_e fp_format_i;
	operand_t   a_i;
	operand_t   b_i;
	logic       out_valid_o;
	result_t    result_o;

	integer  seed;
	int      errors;
	int      checks;
	int      tests_failed;
	int      cycle;
	result_t exp_q[$];
	int      stamp_q[$]; // cycle each input was seen

	hybrid_mul_top hybrid_mul_top_inst (
		.clk         (clk),
		.reset_i     (reset_i),
		.in_valid_i  (in_valid_i),
		.prec_mode_i (prec_mode_i),
		.fp_format_i (fp_format_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.out_valid_o (out_valid_o),
		.result_o    (result_o)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD/2) clk = ~clk;

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// hidden bit sits just above the stored mantissa bits
	function automatic int significand(input fp_format_e fmt, input int e, input int nib);
		int m;
		m = (fmt == FMT_E4M3) ? 3 : 2;
		return (nib % (1 << m)) + ((e != 0) ? (1 << m) : 0);
	endfunction

	function automatic result_t expected_result(input prec_mode_e mode, input fp_format_e fmt,
		input operand_t a, input operand_t b);
		result_t r;
		int ia;
		int ib;
		int ea;
		int eb;
		int sa;
		int sb;
		r = '0;
		if (mode == PREC_INT8) begin
			ia = int'($signed(a.mant));
			ib = int'($signed(b.mant));
			r.int_prod = 16'(ia * ib);
		end else if (mode == PREC_FP8) begin
			for (int l = 0; l < `HM_LANES; l++) begin
				ea = int'(a.exp[l*5 +: 5]);
				eb = int'(b.exp[l*5 +: 5]);
				sa = significand(fmt, ea, int'(a.mant[l*4 +: 4]));
				sb = significand(fmt, eb, int'(b.mant[l*4 +: 4]));
				r.lane[l].sign = a.sign[l] ^ b.sign[l];
				r.lane[l].exp = 6'(((ea == 0) ? 1 : ea) + ((eb == 0) ? 1 : eb)); // subnormal at 1
				r.lane[l].mant = 8'(sa * sb);
			end
		end
		return r;
	endfunction

	task automatic check_int(input logic signed [`HM_INT_PROD_W-1:0] got,
		input logic signed [`HM_INT_PROD_W-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] %0t int_prod is %0d, expected %0d", $time, got, want);
		end
	endtask

	task automatic check_lane(input int l, input fp_lane_t got, input fp_lane_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] %0t lane %0d sign/exp/mant %b/%0d/%0d, expected %b/%0d/%0d", $time,
				l, got.sign, got.exp, got.mant, want.sign, want.exp, want.mant);
		end
	endtask

	task automatic random_operand(input fp_format_e fmt, output operand_t op);
		logic [31:0] rv;
		rv = next_random();
		op = rv[$bits(operand_t)-1:0];
		if (fmt == FMT_E4M3) begin
			op.exp = op.exp & 10'b01111_01111; // 4-bit exponent field
		end
		if (next_random() % 4 == 0) op.exp[4:0] = '0;
		if (next_random() % 4 == 0) op.exp[9:5] = '0;
	endtask

	task automatic drive(input prec_mode_e mode, input fp_format_e fmt,
		input operand_t a, input operand_t b);
		@(posedge clk);
		in_valid_i  <= 1'b1;
		prec_mode_i <= mode;
		fp_format_i <= fmt;
		a_i         <= a;
		b_i         <= b;
	endtask

	task automatic idle();
		@(posedge clk);
		in_valid_i <= 1'b0;
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		idle();
		@(negedge clk);
		while (exp_q.size() != 0) @(negedge clk);
		report_test(name, err_before);
	endtask

	task automatic check_quiet();
		@(negedge clk);
		if (out_valid_o !== 1'b0) begin
			errors++;
			$display("out_valid_o was high at %0t with reset applied or just released", $time);
		end
		if (reset_i && result_o !== '0) begin
			errors++;
			$display("[ERROR] %0t result_o is %h while reset_i is high, expected zero", $time,
				result_o);
		end
	endtask

	// compare outputs first, then queue what goes in on the next edge
	always @(negedge clk) begin
		result_t want;
		int stamp;
		cycle++;
		if (out_valid_o) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("out_valid_o went high at %0t with no input waiting for a result", $time);
			end else begin
				want = exp_q.pop_front();
				stamp = stamp_q.pop_front();
				if (cycle - stamp != `HM_PIPE_DEPTH) begin
					errors++;
					$display("[ERROR] %0t result came %0d cycles after its input", $time,
						cycle - stamp);
				end
				check_int(result_o.int_prod, want.int_prod);
				for (int l = 0; l < `HM_LANES; l++) begin
					check_lane(l, result_o.lane[l], want.lane[l]);
				end
			end
		end
		if (!reset_i && in_valid_i) begin
			exp_q.push_back(expected_result(prec_mode_i, fp_format_i, a_i, b_i));
			stamp_q.push_back(cycle);
		end
	end

	initial begin
		operand_t   a;
		operand_t   b;
		prec_mode_e mode;
		fp_format_e fmt;
		logic [31:0] rv;
		int err0;
		seed = 56822;
		errors = 0;
		checks = 0;
		tests_failed = 0;
		cycle = 0;
		reset_i = 1'b1;
		in_valid_i = 1'b1; // offered during reset, must never come out
		prec_mode_i = PREC_INT8;
		fp_format_i = FMT_E4M3;
		a_i = '0;
		b_i = '0;
		a_i.mant = 8'h93;
		b_i.mant = 8'h6d;

		err0 = errors;
		repeat (RESET_CYCLES) check_quiet();
		@(posedge clk);
		reset_i <= 1'b0;
		in_valid_i <= 1'b0;
		repeat (2) check_quiet();
		report_test("reset", err0);

		err0 = errors;
		for (int i = 0; i < N_CORNER + N_RAND_INT; i++) begin
			random_operand(FMT_E5M2, a); // exp and sign bits must not leak into int8
			random_operand(FMT_E5M2, b);
			if (i < N_CORNER) begin
				a.mant = CORNER_A[i];
				b.mant = CORNER_B[i];
			end
			drive(PREC_INT8, FMT_E4M3, a, b);
		end
		finish_test("int8", err0);

		err0 = errors;
		for (int i = 0; i < N_RAND_FP; i++) begin
			random_operand(FMT_E4M3, a);
			random_operand(FMT_E4M3, b);
			drive(PREC_FP8, FMT_E4M3, a, b);
		end
		finish_test("fp8_e4m3", err0);

		err0 = errors;
		for (int i = 0; i < N_RAND_FP; i++) begin
			random_operand(FMT_E5M2, a);
			random_operand(FMT_E5M2, b);
			drive(PREC_FP8, FMT_E5M2, a, b);
		end
		finish_test("fp8_e5m2", err0);

		err0 = errors;
		for (int i = 0; i < N_STREAM + N_GAPPED; i++) begin
			rv = next_random();
			mode = prec_mode_e'(rv[1:0]);
			fmt = fp_format_e'(rv[2]);
			random_operand(fmt, a);
			random_operand(fmt, b);
			drive(mode, fmt, a, b);
			if (i >= N_STREAM) begin
				repeat (rv[4:3]) idle(); // up to MAX_GAP idle cycles
			end
		end
		finish_test("streaming", err0);

		err0 = errors;
		for (int i = 0; i < N_RSVD; i++) begin
			random_operand(FMT_E5M2, a);
			random_operand(FMT_E5M2, b);
			drive((i % 2 == 0) ? PREC_RSVD2 : PREC_RSVD3, fp_format_e'(i[1]), a, b);
		end
		finish_test("reserved", err0);

		$display("tests: %0d run, %0d with errors; checks: %0d, errors: %0d",
			N_TESTS, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#((TOTAL_SLOTS + 20) * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, results stopped arriving", TOTAL_SLOTS + 20);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/num_format_pkg.sv
verilog/datapath_pkg.sv
verilog/operand_unpack.sv
verilog/partial_product_array.sv
verilog/product_combiner.sv
verilog/hybrid_mul_top.sv
test/hybrid_mul_sva.sv
test/hybrid_mul_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the multiplier testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=hybrid_mul_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module hybrid_mul_tb \
	-f compile.f \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
	exit 0
fi
exit 1
